/* src/rvv_pkg.sv */
package rvv_pkg;

  // register widths
  localparam int vlen = 128;
  localparam int vlenb = vlen / 8;
  localparam int xlen = 32;

  // rob tag and reservation station sizing
  localparam int rob_depth_width = 3;
  localparam int rs_depth = 4;
  localparam int rs_idx_width = $clog2(rs_depth);
  localparam int rs_cnt_width = $clog2(rs_depth + 1);

  // bit index below vlen
  localparam int vstart_width = 7;

  typedef logic [vlen-1:0] vreg_t;
  typedef logic [xlen-1:0] xreg_t;
  typedef logic [rob_depth_width-1:0] rob_tag_t;
  typedef logic [vstart_width-1:0] vstart_t;
  typedef logic [rs_idx_width-1:0] rs_idx_t;
  typedef logic [rs_cnt_width-1:0] rs_cnt_t;
  typedef logic [5:0] funct6_t;

  // funct3 major opcode groups, riscv encoding
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // opi integer logical
  localparam funct6_t VAND = 6'b001001;
  localparam funct6_t VOR  = 6'b001010;
  localparam funct6_t VXOR = 6'b001011;

  // opm mask logical
  localparam funct6_t VMANDN = 6'b011000;
  localparam funct6_t VMAND  = 6'b011001;
  localparam funct6_t VMOR   = 6'b011010;
  localparam funct6_t VMXOR  = 6'b011011;
  localparam funct6_t VMORN  = 6'b011100;
  localparam funct6_t VMNAND = 6'b011101;
  localparam funct6_t VMNOR  = 6'b011110;
  localparam funct6_t VMXNOR = 6'b011111;

  // dispatch payload into the alu reservation station
  typedef struct packed {
    rob_tag_t               rob_entry;
    funct6_t                funct6;
    funct3_e                funct3;
    eew_e                   eew;
    vstart_t                vstart;
    logic                   vm;
    logic [vlenb-1:0]       v0_data;
    vreg_t                  vd_data;
    vreg_t                  vs1_data;
    logic                   vs1_valid;
    rob_tag_t               vs1_tag;
    vreg_t                  vs2_data;
    logic                   vs2_valid;
    rob_tag_t               vs2_tag;
    // scalar or sign-extended imm5
    xreg_t                  rs1_data;
  } alu_uop_t;

  // producer result broadcast
  typedef struct packed {
    rob_tag_t               tag;
    vreg_t                  data;
  } wakeup_t;

  typedef struct packed {
    rob_tag_t               rob_entry;
    vreg_t                  w_data;
    logic                   ignore_vta_vma;
  } alu2rob_t;

endpackage

/* src/rvv_alu_rs.sv */
`timescale 1ns/1ps

module rvv_alu_rs (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dispatch_valid,
  input  rvv_pkg::alu_uop_t dispatch_uop,
  input  logic              wakeup_valid,
  input  rvv_pkg::wakeup_t  wakeup,
  output logic              rs_full,
  output logic              issue_valid,
  output rvv_pkg::alu_uop_t issue_uop
);

  import rvv_pkg::*;

  // index 0 holds the oldest entry
  alu_uop_t              entry_q [rs_depth];
  alu_uop_t              entry_woken [rs_depth];
  alu_uop_t              entry_nxt [rs_depth];
  rs_cnt_t               count;
  rs_cnt_t               cnt_nxt;
  logic [rs_depth-1:0]   entry_ready;
  rs_idx_t               issue_idx;
  logic                  dispatch_fire;

  // capture a matching producer result into a waiting source
  function automatic alu_uop_t wake_operands(
    input alu_uop_t u,
    input logic     wk_valid,
    input wakeup_t  wk
  );
    alu_uop_t w;
    w = u;
    if (wk_valid && !u.vs1_valid && (u.vs1_tag == wk.tag)) begin
      w.vs1_data  = wk.data;
      w.vs1_valid = 1'b1;
    end
    if (wk_valid && !u.vs2_valid && (u.vs2_tag == wk.tag)) begin
      w.vs2_data  = wk.data;
      w.vs2_valid = 1'b1;
    end
    return w;
  endfunction

  assign rs_full       = (count == rs_cnt_t'(rs_depth));
  assign dispatch_fire = dispatch_valid && !rs_full;

  // readiness comes from registered state only
  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_ready[i] = (rs_cnt_t'(i) < count) &&
                       entry_q[i].vs1_valid && entry_q[i].vs2_valid;
    end
  end

  // oldest ready entry wins
  always_comb begin
    issue_valid = 1'b0;
    issue_idx   = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (entry_ready[i]) begin
        issue_valid = 1'b1;
        issue_idx   = rs_idx_t'(i);
      end
    end
  end

  assign issue_uop = entry_q[issue_idx];

  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_woken[i] = wake_operands(entry_q[i], wakeup_valid, wakeup);
    end
  end

  // collapse over the issued slot, then append behind the survivors
  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_nxt[i] = entry_woken[i];
    end
    cnt_nxt = count;
    if (issue_valid) begin
      for (int i = 0; i < rs_depth - 1; i++) begin
        if (i >= issue_idx) begin
          entry_nxt[i] = entry_woken[i+1];
        end
      end
      cnt_nxt = count - 1'b1;
    end
    if (dispatch_fire) begin
      // a same-cycle wakeup is caught on entry as well
      entry_nxt[cnt_nxt[rs_idx_width-1:0]] = wake_operands(dispatch_uop, wakeup_valid,
                                                           wakeup);
      cnt_nxt = cnt_nxt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= cnt_nxt;
    end
  end

  // slots at or above count are don't care
  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_q[i] <= entry_nxt[i];
    end
  end

endmodule

/* src/rvv_alu_unit.sv */
`timescale 1ns/1ps

module rvv_alu_unit (
  input  logic              alu_uop_valid,
  input  rvv_pkg::alu_uop_t alu_uop,
  output logic              result_valid_ex2rob,
  output rvv_pkg::alu2rob_t result_ex2rob
);

  import rvv_pkg::*;

  funct6_t            funct6;
  funct3_e            funct3;
  eew_e               eew;
  vstart_t            vstart;
  logic               vm;

  logic               is_opi;
  logic               is_opm;
  logic               is_vv;
  vreg_t              src1_data;
  vreg_t              op_result;
  logic               mask_op;
  logic               opi_op;

  logic [2:0]         elem_shift;
  logic [vlenb-1:0]   elem_keep;
  vreg_t              keep_bit;
  vreg_t              w_data;

  // split the uop
  assign funct6 = alu_uop.funct6;
  assign funct3 = alu_uop.funct3;
  assign eew    = alu_uop.eew;
  assign vstart = alu_uop.vstart;
  assign vm     = alu_uop.vm;

  assign is_opi = (funct3 == OPIVV) || (funct3 == OPIVX) || (funct3 == OPIVI);
  assign is_opm = (funct3 == OPMVV) || (funct3 == OPMVX);
  assign is_vv  = (funct3 == OPIVV) || (funct3 == OPMVV);

  // scalar operand replicated to every element
  always_comb begin
    if (is_vv) begin
      src1_data = alu_uop.vs1_data;
    end else begin
      case (eew)
        EEW8:    src1_data = {(vlen/8){alu_uop.rs1_data[7:0]}};
        EEW16:   src1_data = {(vlen/16){alu_uop.rs1_data[15:0]}};
        default: src1_data = {(vlen/32){alu_uop.rs1_data}};
      endcase
    end
  end

  // bitwise logic, no element boundaries needed
  always_comb begin
    op_result = '0;
    mask_op   = 1'b0;
    opi_op    = 1'b0;
    if (is_opm) begin
      mask_op = 1'b1;
      case (funct6)
        VMANDN:  op_result = alu_uop.vs2_data & ~src1_data;
        VMAND:   op_result = alu_uop.vs2_data & src1_data;
        VMOR:    op_result = alu_uop.vs2_data | src1_data;
        VMXOR:   op_result = alu_uop.vs2_data ^ src1_data;
        VMORN:   op_result = alu_uop.vs2_data | ~src1_data;
        VMNAND:  op_result = ~(alu_uop.vs2_data & src1_data);
        VMNOR:   op_result = ~(alu_uop.vs2_data | src1_data);
        VMXNOR:  op_result = ~(alu_uop.vs2_data ^ src1_data);
        default: mask_op = 1'b0;
      endcase
    end else if (is_opi) begin
      opi_op = 1'b1;
      case (funct6)
        VAND:    op_result = alu_uop.vs2_data & src1_data;
        VOR:     op_result = alu_uop.vs2_data | src1_data;
        VXOR:    op_result = alu_uop.vs2_data ^ src1_data;
        default: opi_op = 1'b0;
      endcase
    end
  end

  // log2 of element width in bits
  always_comb begin
    case (eew)
      EEW8:    elem_shift = 3'd3;
      EEW16:   elem_shift = 3'd4;
      default: elem_shift = 3'd5;
    endcase
  end

  // prefix and v0 mask per element index
  always_comb begin
    for (int e = 0; e < vlenb; e++) begin
      elem_keep[e] = (e < vstart) || (!vm && !alu_uop.v0_data[e]);
    end
  end

  // mask ops count vstart in bits, opi ops in elements
  always_comb begin
    for (int b = 0; b < vlen; b++) begin
      if (mask_op) begin
        keep_bit[b] = (b < vstart);
      end else begin
        keep_bit[b] = elem_keep[b >> elem_shift];
      end
    end
  end

  // unsupported opcodes retire as zero
  always_comb begin
    if (mask_op || opi_op) begin
      w_data = (keep_bit & alu_uop.vd_data) | (~keep_bit & op_result);
    end else begin
      w_data = '0;
    end
  end

  assign result_valid_ex2rob          = alu_uop_valid;
  assign result_ex2rob.rob_entry      = alu_uop.rob_entry;
  assign result_ex2rob.w_data         = w_data;
  assign result_ex2rob.ignore_vta_vma = mask_op;

endmodule

/* src/rvv_alu_wb.sv */
`timescale 1ns/1ps

module rvv_alu_wb (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              result_valid,
  input  rvv_pkg::alu2rob_t result,
  output logic              rob_valid,
  output rvv_pkg::alu2rob_t rob_result
);

  import rvv_pkg::*;

  // one strobe per issued uop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rob_valid <= 1'b0;
    end else begin
      rob_valid <= result_valid;
    end
  end

  // payload holds between results
  always_ff @(posedge clk) begin
    if (result_valid) begin
      rob_result <= result;
    end
  end

endmodule

/* src/rvv_alu_top.sv */
`timescale 1ns/1ps

module rvv_alu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dispatch_valid,
  input  rvv_pkg::alu_uop_t dispatch_uop,
  input  logic              wakeup_valid,
  input  rvv_pkg::wakeup_t  wakeup,
  output logic              rs_full,
  output logic              rob_valid,
  output rvv_pkg::alu2rob_t rob_result
);

  import rvv_pkg::*;

  logic      issue_valid;
  alu_uop_t  issue_uop;
  logic      result_valid;
  alu2rob_t  result;

  rvv_alu_rs u_rs (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_uop   (dispatch_uop),
    .wakeup_valid   (wakeup_valid),
    .wakeup         (wakeup),
    .rs_full        (rs_full),
    .issue_valid    (issue_valid),
    .issue_uop      (issue_uop)
  );

  rvv_alu_unit u_unit (
    .alu_uop_valid       (issue_valid),
    .alu_uop             (issue_uop),
    .result_valid_ex2rob (result_valid),
    .result_ex2rob       (result)
  );

  rvv_alu_wb u_wb (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .result       (result),
    .rob_valid    (rob_valid),
    .rob_result   (rob_result)
  );

endmodule

/* testbench/rvv_alu_checker.sv */
`timescale 1ns/1ps

module rvv_alu_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dispatch_valid,
  input  rvv_pkg::alu_uop_t dispatch_uop,
  input  logic              rs_full,
  input  logic              wakeup_valid,
  input  rvv_pkg::wakeup_t  wakeup,
  input  logic              rob_valid,
  input  rvv_pkg::alu2rob_t rob_result,
  input  logic              test_done,
  output int                value_errors,
  output int                protocol_errors
);

  import rvv_pkg::*;

  localparam int num_tags = 2 ** rob_depth_width;

  typedef enum logic [1:0] {TAG_IDLE, TAG_LIVE, TAG_DONE} tag_state_e;

  alu_uop_t   uop_q [num_tags];
  tag_state_e state_q [num_tags];
  int         disp_cycle [num_tags];
  int         disp_seq [num_tags];
  int         cycle = 0;
  int         dispatch_count = 0;
  logic       full_seen = 1'b0;
  logic       done_seen = 1'b0;
  logic       passed_older = 1'b0;

  initial begin
    value_errors = 0;
    protocol_errors = 0;
    for (int t = 0; t < num_tags; t++) begin
      state_q[t] = TAG_IDLE;
    end
  end

  // expected write-back derived from the opcode rules
  function automatic alu2rob_t expect_result(input alu_uop_t u);
    alu2rob_t r;
    vreg_t    src1;
    vreg_t    raw;
    logic     legal;
    logic     mask_op;
    logic     keep;
    int       ew;
    int       e;
    ew = (u.eew == EEW8) ? 8 : ((u.eew == EEW16) ? 16 : 32);
    for (int b = 0; b < vlen; b++) begin
      src1[b] = (u.funct3 == OPIVV || u.funct3 == OPMVV) ? u.vs1_data[b] : u.rs1_data[b % ew];
    end
    raw = '0;
    legal = 1'b1;
    mask_op = (u.funct3 == OPMVV);
    if (mask_op) begin
      case (u.funct6)
        VMAND:   raw = u.vs2_data & src1;
        VMNAND:  raw = ~(u.vs2_data & src1);
        VMANDN:  raw = u.vs2_data & ~src1;
        VMOR:    raw = u.vs2_data | src1;
        VMNOR:   raw = ~(u.vs2_data | src1);
        VMORN:   raw = u.vs2_data | ~src1;
        VMXOR:   raw = u.vs2_data ^ src1;
        VMXNOR:  raw = ~(u.vs2_data ^ src1);
        default: legal = 1'b0;
      endcase
    end else if (u.funct3 == OPIVV || u.funct3 == OPIVX || u.funct3 == OPIVI) begin
      case (u.funct6)
        VAND:    raw = u.vs2_data & src1;
        VOR:     raw = u.vs2_data | src1;
        VXOR:    raw = u.vs2_data ^ src1;
        default: legal = 1'b0;
      endcase
    end else begin
      legal = 1'b0;
    end
    r.rob_entry = u.rob_entry;
    r.ignore_vta_vma = legal && mask_op;
    for (int b = 0; b < vlen; b++) begin
      e = b / ew;
      // mask ops count vstart in bits
      keep = mask_op ? (b < u.vstart) : ((e < u.vstart) || (!u.vm && !u.v0_data[e]));
      r.w_data[b] = legal ? (keep ? u.vd_data[b] : raw[b]) : 1'b0;
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [vlen-1:0] got,
                         input logic [vlen-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s = %0h, expected %0h (cycle %0d)", name, got, exp, cycle);
    end
  endtask

  always @(posedge clk) begin
    alu2rob_t exp_r;
    int       t;
    if (rst_n) begin
      cycle++;
      if (dispatch_count == 0) begin
        compare("rob_valid", rob_valid, 1'b0);
        compare("rs_full", rs_full, 1'b0);
      end
      full_seen = full_seen || rs_full;
      // retire before dispatch, a freed tag can come back on this edge
      if (rob_valid && $isunknown(rob_result.rob_entry)) begin
        protocol_errors++;
        $display("rob write-back at cycle %0d carries an unknown rob entry", cycle);
      end else if (rob_valid) begin
        t = int'(rob_result.rob_entry);
        if (state_q[t] == TAG_LIVE) begin
          if (!uop_q[t].vs1_valid || !uop_q[t].vs2_valid) begin
            protocol_errors++;
            $display("rob entry %0d retired at cycle %0d before its source wakeup", t, cycle);
          end
          exp_r = expect_result(uop_q[t]);
          compare("rob_result.w_data", rob_result.w_data, exp_r.w_data);
          compare("rob_result.ignore_vta_vma", rob_result.ignore_vta_vma,
                  exp_r.ignore_vta_vma);
          // strobe is sampled high on the second edge after dispatch
          if (disp_cycle[t] == 1 && cycle - disp_cycle[t] != 2) begin
            protocol_errors++;
            $display("first uop retired %0d edges after dispatch instead of 2",
                     cycle - disp_cycle[t]);
          end
          // an older uop still in flight was overtaken
          for (int i = 0; i < num_tags; i++) begin
            if (state_q[i] == TAG_LIVE && disp_seq[i] < disp_seq[t]) begin
              passed_older = 1'b1;
            end
          end
          state_q[t] = TAG_DONE;
        end else begin
          protocol_errors++;
          $display("rob entry %0d retired at cycle %0d %s", t, cycle,
                   (state_q[t] == TAG_DONE) ? "a second time" : "without being dispatched");
        end
      end
      if (dispatch_valid && !rs_full) begin
        t = int'(dispatch_uop.rob_entry);
        uop_q[t] = dispatch_uop;
        state_q[t] = TAG_LIVE;
        dispatch_count++;
        disp_seq[t] = dispatch_count;
        disp_cycle[t] = (dispatch_count == 1) ? 1 : 0;
        if (dispatch_count == 1) begin
          cycle = 1;
        end
      end
      // same-edge wakeups reach a uop dispatched on this edge too
      if (wakeup_valid) begin
        for (int i = 0; i < num_tags; i++) begin
          if (state_q[i] == TAG_LIVE && !uop_q[i].vs1_valid && uop_q[i].vs1_tag == wakeup.tag) begin
            uop_q[i].vs1_data = wakeup.data;
            uop_q[i].vs1_valid = 1'b1;
          end
          if (state_q[i] == TAG_LIVE && !uop_q[i].vs2_valid && uop_q[i].vs2_tag == wakeup.tag) begin
            uop_q[i].vs2_data = wakeup.data;
            uop_q[i].vs2_valid = 1'b1;
          end
        end
      end
      if (test_done && !done_seen) begin
        done_seen = 1'b1;
        for (int i = 0; i < num_tags; i++) begin
          if (state_q[i] == TAG_LIVE) begin
            protocol_errors++;
            $display("rob entry %0d was dispatched and never retired", i);
          end
        end
        if (!full_seen) begin
          protocol_errors++;
          $display("rs_full never went high although the station was filled");
        end
        if (!passed_older) begin
          protocol_errors++;
          $display("no younger uop ever retired ahead of an older waiting one");
        end
      end
    end
  end

endmodule

/* testbench/tb_rvv_alu.sv */
`timescale 1ns/1ps

module tb_rvv_alu;

  import rvv_pkg::*;

  localparam int num_random = 200;
  localparam int num_uops = num_random + 5;
  localparam int cycle_limit = 40 * num_uops + 200;
  localparam int num_tags = 2 ** rob_depth_width;
  localparam funct6_t mask_ops [8] = '{VMAND, VMNAND, VMANDN, VMOR,
                                       VMNOR, VMORN, VMXOR, VMXNOR};
  localparam funct6_t opi_ops [3] = '{VAND, VOR, VXOR};

  // broadcast waiting for its cycle
  typedef struct packed {
    rob_tag_t    tag;
    vreg_t       data;
    logic [31:0] due;
  } pending_wakeup_t;

  logic            clk;
  logic            rst_n;
  logic            dispatch_valid;
  alu_uop_t        dispatch_uop;
  logic            wakeup_valid;
  wakeup_t         wakeup;
  logic            rs_full;
  logic            rob_valid;
  alu2rob_t        rob_result;
  logic            test_done;
  int              value_errors;
  int              protocol_errors;
  int              cycle = 0;
  // tags held by uops in flight or by producers not yet broadcast
  logic [num_tags-1:0] tag_busy;
  pending_wakeup_t wake_q [$];

  rvv_alu_top uut (.*);
  rvv_alu_checker chk (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout: run stopped at cycle %0d with uops still in flight", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int free_tag();
    for (int t = 0; t < num_tags; t++) begin
      if (!tag_busy[t]) begin
        return t;
      end
    end
    return -1;
  endfunction

  function automatic vreg_t random_vreg();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic alu_uop_t random_uop();
    alu_uop_t   u;
    int         kind;
    logic [4:0] imm;
    u = '0;
    kind = int'($urandom % 16);
    imm = 5'($urandom);
    u.eew = eew_e'($urandom % 3);
    u.vm = 1'($urandom);
    u.v0_data = vlenb'($urandom);
    u.vd_data = random_vreg();
    u.vs1_data = random_vreg();
    u.vs2_data = random_vreg();
    u.rs1_data = $urandom;
    u.funct3 = OPIVV;
    if (kind < 8) begin
      u.funct3 = OPMVV;
      u.funct6 = mask_ops[kind];
      u.vstart = ($urandom % 2 == 0) ? '0 : vstart_t'($urandom);
    end else if (kind < 14) begin
      u.funct6 = opi_ops[kind % 3];
      u.vstart = ($urandom % 2 == 0) ? '0 : vstart_t'($urandom % 20);
      case ($urandom % 3)
        1: u.funct3 = OPIVX;
        2: begin
          u.funct3 = OPIVI;
          u.rs1_data = {{(xlen-5){imm[4]}}, imm};
        end
        default: u.funct3 = OPIVV;
      endcase
    end else begin
      // mostly opcodes the unit does not support
      u.funct6 = funct6_t'($urandom);
      if (kind == 15) begin
        u.funct3 = OPMVV;
      end
    end
    return u;
  endfunction

  // reserve a producer tag, broadcast min_delay or more cycles later
  task automatic add_producer(input int min_delay, output logic waiting, output rob_tag_t tag);
    pending_wakeup_t w;
    int              p;
    p = free_tag();
    waiting = 1'b0;
    tag = '0;
    if (p >= 0) begin
      tag_busy[p] = 1'b1;
      w.tag = rob_tag_t'(p);
      w.data = random_vreg();
      w.due = 32'(cycle + min_delay) + ($urandom % 8);
      wake_q.push_back(w);
      waiting = 1'b1;
      tag = w.tag;
    end
  endtask

  task automatic drive_cycle(input logic want, input int wait1_pct, input int wait2_pct,
                             input int min_delay, output logic sent);
    alu_uop_t u;
    logic     waiting;
    rob_tag_t tag;
    int       t;
    int       pick;
    @(negedge clk);
    // a tag is free again once its retire or broadcast has been sampled
    if (wakeup_valid) begin
      tag_busy[wakeup.tag] = 1'b0;
    end
    if (rob_valid) begin
      tag_busy[rob_result.rob_entry] = 1'b0;
    end
    dispatch_valid = 1'b0;
    wakeup_valid = 1'b0;
    sent = 1'b0;
    t = free_tag();
    if (want && !rs_full && t >= 0) begin
      u = random_uop();
      tag_busy[t] = 1'b1;
      u.rob_entry = rob_tag_t'(t);
      u.vs1_valid = 1'b1;
      u.vs2_valid = 1'b1;
      if (int'($urandom % 100) < wait1_pct) begin
        add_producer(min_delay, waiting, tag);
        u.vs1_valid = !waiting;
        u.vs1_tag = tag;
      end
      if (int'($urandom % 100) < wait2_pct) begin
        add_producer(min_delay, waiting, tag);
        u.vs2_valid = !waiting;
        u.vs2_tag = tag;
      end
      dispatch_uop = u;
      dispatch_valid = 1'b1;
      sent = 1'b1;
    end
    // one broadcast per cycle, the first one that is due
    pick = -1;
    foreach (wake_q[i]) begin
      if (pick < 0 && int'(wake_q[i].due) <= cycle) begin
        pick = i;
      end
    end
    if (pick >= 0) begin
      wakeup.tag = wake_q[pick].tag;
      wakeup.data = wake_q[pick].data;
      wakeup_valid = 1'b1;
      wake_q.delete(pick);
    end
  endtask

  task automatic drain();
    logic sent;
    while (tag_busy != '0 || wake_q.size() != 0) begin
      drive_cycle(1'b0, 0, 0, 0, sent);
    end
  endtask

  initial begin
    logic sent;
    int   left;
    void'($urandom(32'h8ada_1edb));
    rst_n = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_uop = '0;
    wakeup_valid = 1'b0;
    wakeup = '0;
    test_done = 1'b0;
    tag_busy = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // single ready uop into the empty station
    do begin
      drive_cycle(1'b1, 0, 0, 0, sent);
    end while (!sent);
    drain();
    // four uops stuck on late producers fill the station
    left = 4;
    while (left > 0) begin
      drive_cycle(1'b1, 100, 0, 20, sent);
      if (sent) begin
        left--;
      end
    end
    left = num_random;
    while (left > 0) begin
      drive_cycle(($urandom % 10) < 7, 25, 25, 0, sent);
      if (sent) begin
        left--;
      end
    end
    drain();
    test_done = 1'b1;
    repeat (2) @(negedge clk);
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
src/rvv_pkg.sv
src/rvv_alu_rs.sv
src/rvv_alu_unit.sv
src/rvv_alu_wb.sv
src/rvv_alu_top.sv
testbench/rvv_alu_checker.sv
testbench/tb_rvv_alu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_rvv_alu -f src.f -o sim_rvv_alu
./obj_dir/sim_rvv_alu > sim.log
cat sim.log
if grep -qx "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1
